/* hw/background_layer.sv */
// ##################################################
// background_layer
// wall, bar and banner regions under the beam
// ##################################################
`timescale 1ns/100ps
`include "vga_macros.svh"

module background_layer import vga_pkg::*; (
    input  logic         clock_25,
    input  logic         reset,
    input  beam_t        beam_now,
    input  game_state_t  game_state,
    input  logic [5:0]   score,
    input  logic [5:0]   time_left,
    output layer_flags_t flags
);

    logic [9:0]   score_end;
    logic [9:0]   time_end;
    logic         in_game;
    logic         in_outer;
    logic         in_score_row;
    logic         in_time_row;
    logic         in_banner;
    layer_flags_t flags_next;

    // bar ends one pixel before these
    assign score_end = 10'(`BAR_X_MIN + `BAR_UNIT * score);
    assign time_end  = 10'(`BAR_X_MIN + `BAR_UNIT * time_left);

    assign in_game = (beam_now.x >= `GAME_X_MIN) && (beam_now.x <= `GAME_X_MAX) &&
                     (beam_now.y >= `GAME_Y_MIN) && (beam_now.y <= `GAME_Y_MAX);

    // game area grown by the wall width
    assign in_outer = (beam_now.x >= `GAME_X_MIN - `WALL_WIDTH) &&
                      (beam_now.x <= `GAME_X_MAX + `WALL_WIDTH) &&
                      (beam_now.y >= `GAME_Y_MIN - `WALL_WIDTH) &&
                      (beam_now.y <= `GAME_Y_MAX + `WALL_WIDTH);

    assign in_score_row = (beam_now.y >= `SCORE_Y_MIN) && (beam_now.y <= `SCORE_Y_MAX);
    assign in_time_row  = (beam_now.y >= `TIME_Y_MIN) && (beam_now.y <= `TIME_Y_MAX);

    assign in_banner = (beam_now.x >= `BANNER_X_MIN) && (beam_now.x <= `BANNER_X_MAX) &&
                       (beam_now.y >= `BANNER_Y_MIN) && (beam_now.y <= `BANNER_Y_MAX);

    always_comb begin
        flags_next.wall = in_outer && !in_game;   // 8 pixel ring
        flags_next.bar  = (beam_now.x >= `BAR_X_MIN) &&
                          ((in_score_row && (beam_now.x < score_end)) ||
                           (in_time_row && (beam_now.x < time_end)));
        flags_next.banner_start = in_banner && (game_state == state_start);
        flags_next.banner_over  = in_banner && (game_state == state_over);
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            flags <= '0;
        end else begin
            flags <= flags_next;
        end
    end

endmodule

/* hw/playfield_layer.sv */
// ##################################################
// playfield_layer
// tile colour memory, written by strobe, read under the beam
// ##################################################
`timescale 1ns/100ps
`include "vga_macros.svh"

module playfield_layer import vga_pkg::*; (
    input  logic           clock_25,
    input  logic           reset,
    input  beam_t          beam_now,
    input  logic           tile_write,
    input  logic [7:0]     tile_addr,
    input  logic [1:0]     tile_color,
    output playfield_pix_t tile_pix
);

    logic [1:0] tile_mem [0:`TILE_COUNT-1];
    logic [9:0] game_x;
    logic [9:0] game_y;
    logic [7:0] tile_index;
    logic       in_game;

    // position relative to the top left of the game area
    assign game_x = beam_now.x - 10'(`GAME_X_MIN);
    assign game_y = beam_now.y - 10'(`GAME_Y_MIN);

    assign in_game = (beam_now.x >= `GAME_X_MIN) && (beam_now.x <= `GAME_X_MAX) &&
                     (beam_now.y >= `GAME_Y_MIN) && (beam_now.y <= `GAME_Y_MAX);

    // row * 16 + column
    assign tile_index = 8'((game_y >> `TILE_SHIFT) * `TILE_COLS + (game_x >> `TILE_SHIFT));

    // all tiles start black
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `TILE_COUNT; i++) begin
                tile_mem[i] <= `CODE_BLACK;
            end
        end else if (tile_write) begin
            tile_mem[tile_addr] <= tile_color;
        end
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            tile_pix <= '0;
        end else begin
            tile_pix.game_enable <= in_game;
            // index is only meaningful inside the area
            tile_pix.color_data  <= in_game ? tile_mem[tile_index] : `CODE_BLACK;
        end
    end

    tile_addr_in_range: assert property (
        @(posedge clock_25) disable iff (!reset)
        tile_write |-> (tile_addr < `TILE_COUNT)
    ) else $error("tile write beyond the 16x12 tile map");

endmodule

/* hw/vga_controller.sv */
// ##################################################
// vga_controller
// priority merge of both layers into 10-bit rgb
// ##################################################
`timescale 1ns/100ps
`include "vga_macros.svh"

module vga_controller import vga_pkg::*; (
    input  logic           clock_25,
    input  logic           reset,
    input  beam_t          beam_now,
    input  layer_flags_t   flags,
    input  playfield_pix_t tile_pix,
    output pixel_rgb_t     rgb,
    output logic           hsync,
    output logic           vsync
);

    beam_t      beam_d1;    // lines up with the layer outputs
    pixel_rgb_t rgb_next;

    function automatic pixel_rgb_t code_to_rgb(input logic [1:0] code);
        case (code)
            `CODE_GREEN: code_to_rgb = `COLOR_GREEN;
            `CODE_RED:   code_to_rgb = `COLOR_RED_SOFT;
            `CODE_WHITE: code_to_rgb = `COLOR_WHITE;
            default:     code_to_rgb = '0;
        endcase
    endfunction

    // first match wins
    always_comb begin
        if (!beam_d1.display_area) begin
            rgb_next = '0;
        end else if (flags.banner_start) begin
            rgb_next = `COLOR_BLUE_SOFT;
        end else if (flags.banner_over) begin
            rgb_next = `COLOR_RED_SOFT;
        end else if (flags.wall) begin
            rgb_next = `COLOR_WHITE;
        end else if (tile_pix.game_enable) begin
            rgb_next = code_to_rgb(tile_pix.color_data);
        end else if (flags.bar) begin
            rgb_next = `COLOR_GREEN;
        end else begin
            rgb_next = '0;
        end
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            beam_d1       <= '0;
            beam_d1.hsync <= 1'b1;
            beam_d1.vsync <= 1'b1;
        end else begin
            beam_d1 <= beam_now;
        end
    end

    // syncs leave in the same stage as the colour
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            rgb   <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            rgb   <= rgb_next;
            hsync <= beam_d1.hsync;
            vsync <= beam_d1.vsync;
        end
    end

    blank_outside_display: assert property (
        @(posedge clock_25) disable iff (!reset)
        !beam_d1.display_area |=> (rgb == '0)
    ) else $error("colour driven outside the display area");

endmodule

/* hw/vga_display_top.sv */
// ##################################################
// vga_display_top
// sync generator, both layers and colour merge
// ##################################################
`timescale 1ns/100ps

module vga_display_top import vga_pkg::*; (
    input  logic        clock_25,
    input  logic        reset,
    input  game_state_t game_state,
    input  logic [5:0]  score,
    input  logic [5:0]  time_left,
    input  logic        tile_write,
    input  logic [7:0]  tile_addr,
    input  logic [1:0]  tile_color,
    output pixel_rgb_t  rgb,
    output logic        hsync,
    output logic        vsync
);

    beam_t          beam_now;
    layer_flags_t   flags;
    playfield_pix_t tile_pix;

    vga_sync_gen sync_gen0 (
        .clock_25 (clock_25),
        .reset    (reset),
        .beam_now (beam_now)
    );

    background_layer background0 (
        .clock_25   (clock_25),
        .reset      (reset),
        .beam_now   (beam_now),
        .game_state (game_state),
        .score      (score),
        .time_left  (time_left),
        .flags      (flags)
    );

    playfield_layer playfield0 (
        .clock_25   (clock_25),
        .reset      (reset),
        .beam_now   (beam_now),
        .tile_write (tile_write),
        .tile_addr  (tile_addr),
        .tile_color (tile_color),
        .tile_pix   (tile_pix)
    );

    vga_controller controller0 (
        .clock_25 (clock_25),
        .reset    (reset),
        .beam_now (beam_now),
        .flags    (flags),
        .tile_pix (tile_pix),
        .rgb      (rgb),
        .hsync    (hsync),
        .vsync    (vsync)
    );

endmodule

/* hw/vga_pkg.sv */
// ##################################################
// vga_pkg
// types shared by the display pixel path
// ##################################################
package vga_pkg;

    // output colour, red in the top bits
    typedef struct packed {
        logic [9:0] red;
        logic [9:0] green;
        logic [9:0] blue;
    } pixel_rgb_t;

    // beam position and timing flags
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       display_area;
        logic       hsync;          // active low
        logic       vsync;          // active low
    } beam_t;

    typedef enum logic [1:0] {
        state_play  = 2'd0,
        state_start = 2'd1,
        state_over  = 2'd2
    } game_state_t;

    // background regions under the beam
    typedef struct packed {
        logic wall;
        logic bar;
        logic banner_start;
        logic banner_over;
    } layer_flags_t;

    typedef struct packed {
        logic       game_enable;
        logic [1:0] color_data;     // colour code of the tile
    } playfield_pix_t;

endpackage

/* hw/vga_sync_gen.sv */
// ##################################################
// vga_sync_gen
// 800x525 beam counters with active-low syncs
// ##################################################
`timescale 1ns/100ps
`include "vga_macros.svh"

module vga_sync_gen import vga_pkg::*; (
    input  logic  clock_25,
    input  logic  reset,
    output beam_t beam_now
);

    logic [9:0] x_next;
    logic [9:0] y_next;
    beam_t      beam_next;

    // wrap at end of line and end of frame
    always_comb begin
        x_next = beam_now.x + 10'd1;
        y_next = beam_now.y;
        if (beam_now.x == `H_TOTAL - 1) begin
            x_next = 10'd0;
            if (beam_now.y == `V_TOTAL - 1) begin
                y_next = 10'd0;
            end else begin
                y_next = beam_now.y + 10'd1;
            end
        end
    end

    // flags follow the next position so the struct stays consistent
    always_comb begin
        beam_next.x            = x_next;
        beam_next.y            = y_next;
        beam_next.display_area = (x_next < `H_ACTIVE) && (y_next < `V_ACTIVE);
        beam_next.hsync        = !((x_next >= `H_SYNC_START) && (x_next < `H_SYNC_END));
        beam_next.vsync        = !((y_next >= `V_SYNC_START) && (y_next < `V_SYNC_END));
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            beam_now.x            <= 10'd0;
            beam_now.y            <= 10'd0;
            beam_now.display_area <= 1'b1;   // (0,0) is visible
            beam_now.hsync        <= 1'b1;
            beam_now.vsync        <= 1'b1;
        end else begin
            beam_now <= beam_next;
        end
    end

    beam_in_frame: assert property (
        @(posedge clock_25) disable iff (!reset)
        (beam_now.x < `H_TOTAL) && (beam_now.y < `V_TOTAL)
    ) else $error("beam outside the 800x525 frame");

endmodule

/* include/vga_macros.svh */
// ##################################################
// vga display constants
// timing, screen regions and colour values
// ##################################################
`ifndef VGA_MACROS_SVH
`define VGA_MACROS_SVH

// 640x480 at 25 MHz
`define H_ACTIVE      640
`define H_FRONT       16
`define H_SYNC        96
`define H_BACK        48
`define H_SYNC_START  (`H_ACTIVE + `H_FRONT)
`define H_SYNC_END    (`H_SYNC_START + `H_SYNC)
`define H_TOTAL       (`H_SYNC_END + `H_BACK)

`define V_ACTIVE      480
`define V_FRONT       10
`define V_SYNC        2
`define V_BACK        33
`define V_SYNC_START  (`V_ACTIVE + `V_FRONT)
`define V_SYNC_END    (`V_SYNC_START + `V_SYNC)
`define V_TOTAL       (`V_SYNC_END + `V_BACK)

// game area, 16x12 tiles of 32 pixels
`define GAME_X_MIN    64
`define GAME_X_MAX    575
`define GAME_Y_MIN    64
`define GAME_Y_MAX    447
`define TILE_SHIFT    5
`define TILE_COLS     16
`define TILE_ROWS     12
`define TILE_COUNT    (`TILE_COLS * `TILE_ROWS)
`define WALL_WIDTH    8

// bars above the game area
`define SCORE_Y_MIN   16
`define SCORE_Y_MAX   23
`define TIME_Y_MIN    32
`define TIME_Y_MAX    39
`define BAR_X_MIN     64
`define BAR_UNIT      4

`define BANNER_X_MIN  192
`define BANNER_X_MAX  447
`define BANNER_Y_MIN  224
`define BANNER_Y_MAX  255

// tile colour codes
`define CODE_BLACK    2'd0
`define CODE_GREEN    2'd1
`define CODE_RED      2'd2
`define CODE_WHITE    2'd3

// red, green, blue
`define COLOR_WHITE     {10'b1111111111, 10'b1111111111, 10'b1111111111}
`define COLOR_GREEN     {10'b0000000000, 10'b1100001111, 10'b0000000000}
`define COLOR_RED_SOFT  {10'b1111110000, 10'b1001100000, 10'b1001100000}
`define COLOR_BLUE_SOFT {10'b0010100000, 10'b0010100000, 10'b1101100000}

`endif

/* project.f */
+incdir+include
hw/vga_pkg.sv
hw/vga_sync_gen.sv
hw/background_layer.sv
hw/playfield_layer.sv
hw/vga_controller.sv
hw/vga_display_top.sv
verif/vga_display_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the vga display testbench with verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log
sim_name=vga_display_sim

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

rm -rf obj_dir "$log_file"

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module vga_display_tb \
    --Mdir obj_dir -o "$sim_name"
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/"$sim_name" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" "$log_file"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $log_file"
    exit 1
fi

/* verif/vga_display_tb.sv */
// ##################################################
// vga_display_tb
// per-pixel compare of the display top against a model
// ##################################################
`timescale 1ns/100ps
`include "vga_macros.svh"

module vga_display_tb import vga_pkg::*; ();

    // one expected pin state, with the beam it belongs to
    typedef struct packed {
        pixel_rgb_t rgb;
        logic [1:0] syncs;      // hsync, vsync
        logic [9:0] x;
        logic [9:0] y;
    } expect_t;

    logic        clock_25;
    logic        reset;
    game_state_t game_state;
    logic [5:0]  score;
    logic [5:0]  time_left;
    logic        tile_write;
    logic [7:0]  tile_addr;
    logic [1:0]  tile_color;
    pixel_rgb_t  rgb;
    logic        hsync;
    logic        vsync;

    integer seed;
    int     pixels_checked;
    int     model_x;
    int     model_y;
    int     fill_count;
    expect_t exp_d1;
    expect_t exp_d2;
    logic [`TILE_COUNT-1:0][1:0] shadow_tiles;

    vga_display_top dut0 (
        .clock_25   (clock_25),
        .reset      (reset),
        .game_state (game_state),
        .score      (score),
        .time_left  (time_left),
        .tile_write (tile_write),
        .tile_addr  (tile_addr),
        .tile_color (tile_color),
        .rgb        (rgb),
        .hsync      (hsync),
        .vsync      (vsync)
    );

    always #50 clock_25 = ~clock_25;   // 100 ns period

    task automatic report_failure();
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_rgb(input pixel_rgb_t actual, input pixel_rgb_t expected,
                             input int x, input int y);
        pixels_checked++;
        if (actual !== expected) begin
            $display("mismatch at %0t: rgb %h, expected %h, beam x=%0d y=%0d",
                     $time, actual, expected, x, y);
            report_failure();
        end
    endtask

    task automatic check_sync(input logic [1:0] actual, input logic [1:0] expected,
                              input int x, input int y);
        if (actual !== expected) begin
            $display("mismatch at %0t: hsync/vsync %b, expected %b, beam x=%0d y=%0d",
                     $time, actual, expected, x, y);
            report_failure();
        end
    endtask

    task automatic check_count(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            report_failure();
        end
    endtask

    // colour of one pixel, straight from the region and priority rules
    function automatic pixel_rgb_t expected_rgb(input int x, input int y,
                                                input game_state_t state,
                                                input int score_units, input int time_units,
                                                input logic [`TILE_COUNT-1:0][1:0] tiles);
        bit in_game;
        bit in_ring;
        bit in_banner;
        int tile_index;
        logic [1:0] code;
        if (x >= `H_ACTIVE || y >= `V_ACTIVE) return '0;
        in_game = x >= `GAME_X_MIN && x <= `GAME_X_MAX && y >= `GAME_Y_MIN && y <= `GAME_Y_MAX;
        in_ring = !in_game &&
                  x >= `GAME_X_MIN - `WALL_WIDTH && x <= `GAME_X_MAX + `WALL_WIDTH &&
                  y >= `GAME_Y_MIN - `WALL_WIDTH && y <= `GAME_Y_MAX + `WALL_WIDTH;
        in_banner = x >= `BANNER_X_MIN && x <= `BANNER_X_MAX &&
                    y >= `BANNER_Y_MIN && y <= `BANNER_Y_MAX;
        if (in_banner && state == state_start) return `COLOR_BLUE_SOFT;
        if (in_banner && state == state_over) return `COLOR_RED_SOFT;
        if (in_ring) return `COLOR_WHITE;
        if (in_game) begin
            tile_index = ((y - `GAME_Y_MIN) / 32) * `TILE_COLS + (x - `GAME_X_MIN) / 32;
            code = tiles[tile_index];
            case (code)
                `CODE_GREEN: return `COLOR_GREEN;
                `CODE_RED:   return `COLOR_RED_SOFT;
                `CODE_WHITE: return `COLOR_WHITE;
                default:     return '0;
            endcase
        end
        if (x >= `BAR_X_MIN) begin
            if (y >= `SCORE_Y_MIN && y <= `SCORE_Y_MAX &&
                x < `BAR_X_MIN + `BAR_UNIT * score_units) return `COLOR_GREEN;
            if (y >= `TIME_Y_MIN && y <= `TIME_Y_MAX &&
                x < `BAR_X_MIN + `BAR_UNIT * time_units) return `COLOR_GREEN;
        end
        return '0;
    endfunction

    // model follows the beam, pins lag it by two clocks
    always @(negedge clock_25) begin : compare_pixels
        expect_t fresh;
        if (!reset) begin
            model_x = 0;
            model_y = 0;
            fill_count = 0;
            shadow_tiles = '0;      // tiles come up black
        end else begin
            fresh.rgb = expected_rgb(model_x, model_y, game_state, int'(score),
                                     int'(time_left), shadow_tiles);
            fresh.syncs[1] = !(model_x >= `H_SYNC_START && model_x < `H_SYNC_END);
            fresh.syncs[0] = !(model_y >= `V_SYNC_START && model_y < `V_SYNC_END);
            fresh.x = 10'(model_x);
            fresh.y = 10'(model_y);
            if (fill_count >= 2) begin
                check_rgb(rgb, exp_d2.rgb, int'(exp_d2.x), int'(exp_d2.y));
                check_sync({hsync, vsync}, exp_d2.syncs, int'(exp_d2.x), int'(exp_d2.y));
            end else begin
                fill_count++;
            end
            exp_d2 = exp_d1;
            exp_d1 = fresh;
            if (tile_write) shadow_tiles[tile_addr] = tile_color;   // seen from next clock
            if (model_x == `H_TOTAL - 1) begin
                model_x = 0;
                model_y = (model_y == `V_TOTAL - 1) ? 0 : model_y + 1;
            end else begin
                model_x = model_x + 1;
            end
        end
    end

    // counts clocks up to the next falling edge of hsync or vsync
    task automatic wait_sync_fall(input bit use_vsync, input int limit, output int cycles);
        logic prev;
        logic now;
        bit   found;
        @(negedge clock_25);
        prev = use_vsync ? vsync : hsync;
        cycles = 1;     // the edge above is one clock
        found = 0;
        while (!found && cycles < limit) begin
            @(negedge clock_25);
            cycles++;
            now = use_vsync ? vsync : hsync;
            if (prev && !now) found = 1;
            prev = now;
        end
        if (!found) begin
            $display("timeout at %0t waiting for %s to fall", $time, use_vsync ? "vsync" : "hsync");
            report_failure();
        end
    endtask

    initial begin
        int cycles;
        int gap;
        int frame_limit;
        seed = 49;
        clock_25 = 1'b0;
        reset = 1'b0;
        game_state = state_play;
        score = '0;
        time_left = '0;
        tile_write = 1'b0;
        tile_addr = '0;
        tile_color = '0;
        pixels_checked = 0;
        frame_limit = `H_TOTAL * `V_TOTAL + 100;

        repeat (5) @(posedge clock_25);
        reset <= 1'b1;

        // blank bars and a black playfield first
        wait_sync_fall(1, frame_limit, cycles);
        wait_sync_fall(1, frame_limit, cycles);
        check_count(cycles, `H_TOTAL * `V_TOTAL, "frame length in clocks");
        wait_sync_fall(0, `H_TOTAL + 100, cycles);
        wait_sync_fall(0, `H_TOTAL + 100, cycles);
        check_count(cycles, `H_TOTAL, "line length in clocks");

        for (int frame = 0; frame < 4; frame++) begin
            @(posedge clock_25);
            score <= 6'($random(seed));
            time_left <= 6'($random(seed));
            case (frame)
                1:       game_state <= state_start;
                2:       game_state <= state_over;
                default: game_state <= state_play;
            endcase
            repeat (48) begin
                gap = 1 + ($unsigned($random(seed)) % 6000);
                repeat (gap) @(posedge clock_25);
                tile_write <= 1'b1;
                tile_addr <= 8'($unsigned($random(seed)) % `TILE_COUNT);
                tile_color <= 2'($random(seed));
                @(posedge clock_25);
                tile_write <= 1'b0;
            end
            wait_sync_fall(1, frame_limit, cycles);
        end

        @(negedge clock_25);
        if (pixels_checked == 0) begin
            $display("no pixel was compared during the run");
            report_failure();
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule
